//--- ice51.f
src/ice51_pkg.sv
src/insn_if.sv
src/uart_rx_loader.sv
src/uart_tx.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/ice51.sv
dv/ice51_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := ice51_tb
RTL_TOP   := ice51
FILELIST  := ice51.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/ice51_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ice51_tb
   import ice51_pkg::*;
();

   logic        i_clk;
   logic        i_nrst      = 1'b0;
   logic        i_uart_rx   = 1'b1;  // line idles high
   byte_t       i_code_data = 8'h00;
   logic        o_uart_tx;
   logic        o_code_wr;
   code_addr_t  o_code_addr;
   byte_t       o_code_data;

   byte_t       code_mem [CODE_DEPTH];
   byte_t       image [CODE_DEPTH];  // program image sent over the uart
   int          wp;                  // assembler write pointer
   logic [31:0] lfsr_state;

   code_addr_t  wr_addr [$];
   byte_t       wr_data [$];
   byte_t       rx_bytes [$];
   byte_t       exp_bytes [$];

   logic        mon_active = 1'b0;
   int          mon_cnt;
   byte_t       mon_shift;

   int          checks     = 0;
   int          value_errs = 0;
   int          other_errs = 0;

   ice51 dut (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .i_code_data (i_code_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   ////////////////////////////////////////
   // code memory and monitors

   always @(posedge i_clk) begin
      if (o_code_wr) code_mem[o_code_addr] <= o_code_data;
      i_code_data <= code_mem[o_code_addr];  // one cycle read latency
   end

   always @(negedge i_clk) begin
      if (i_nrst && o_code_wr) begin
         wr_addr.push_back(o_code_addr);
         wr_data.push_back(o_code_data);
      end
   end

   // uart monitor, counts from the first low sample and samples mid-bit
   always @(negedge i_clk) begin
      if (!i_nrst) begin
         mon_active = 1'b0;
      end else if (!mon_active) begin
         if (!o_uart_tx) begin
            mon_active = 1'b1;
            mon_cnt    = 0;
         end
      end else begin
         mon_cnt = mon_cnt + 1;
         if (mon_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
            case (mon_cnt / CLKS_PER_BIT)
               0: begin
                  if (o_uart_tx) begin
                     other_errs++;
                     mon_active = 1'b0;
                     $display("ERROR: start bit on o_uart_tx was high at mid-bit");
                  end
               end
               9: begin
                  mon_active = 1'b0;
                  if (o_uart_tx) begin
                     rx_bytes.push_back(mon_shift);
                  end else begin
                     other_errs++;
                     $display("ERROR: stop bit on o_uart_tx was low");
                  end
               end
               default: mon_shift = {o_uart_tx, mon_shift[7:1]};  // lsb first
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // random numbers and checks

   function automatic logic lfsr_bit();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;  // x^32+x^22+x^2+x+1
      return out;
   endfunction

   function automatic byte_t rand_byte();
      byte_t v;
      v = 8'h00;
      for (int i = 0; i < 8; i++) v = {v[6:0], lfsr_bit()};
      return v;
   endfunction

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      checks++;
      if (act !== exp) begin
         value_errs++;
         $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input code_addr_t exp, input code_addr_t act);
      checks++;
      if (act !== exp) begin
         value_errs++;
         $display("FAILED %s: expected 0x%03h, actual 0x%03h", name, exp, act);
      end
   endtask

   ////////////////////////////////////////
   // small assembler

   task automatic emit_byte(input byte_t b);
      image[wp] = b;
      wp        = wp + 1;
   endtask

   function automatic byte_t rn_op(input opcode_e base, input int n);
      return byte_t'(base) | byte_t'(n);
   endfunction

   task automatic mov_a_imm(input byte_t v);
      emit_byte(OP_MOV_A_IMM);
      emit_byte(v);
   endtask

   task automatic mov_dptr_imm(input dptr_t v);
      emit_byte(OP_MOV_DPTR);
      emit_byte(v[15:8]);
      emit_byte(v[7:0]);
   endtask

   task automatic branch_back(input opcode_e op, input int target);
      emit_byte(op);
      emit_byte(byte_t'(target - (wp + 1)));  // relative to the next insn
   endtask

   task automatic branch_fwd(input opcode_e op, output int loc);
      emit_byte(op);
      loc = wp;
      emit_byte(8'h00);  // filled in by land_branch
   endtask

   task automatic land_branch(input int loc);
      image[loc] = byte_t'(wp - (loc + 1));
   endtask

   // acc parked in r7 while busy is polled, then sent
   task automatic send_acc();
      int poll;
      emit_byte(rn_op(OP_MOV_RN_A, 7));
      poll = wp;
      mov_dptr_imm(STATUS_ADDR);
      emit_byte(OP_MOVX_A_DPTR);
      branch_back(OP_JNZ, poll);
      emit_byte(rn_op(OP_MOV_A_RN, 7));
      mov_dptr_imm(TX_ADDR);
      emit_byte(OP_MOVX_DPTR_A);
   endtask

   task automatic send_acc_expect(input byte_t exp);
      exp_bytes.push_back(exp);
      send_acc();
   endtask

   // two paths sending different markers, only the taken one is expected
   task automatic branch_pair(input opcode_e op, input logic taken,
                              input byte_t mark_taken, input byte_t mark_fall);
      int l_taken;
      int l_join;
      branch_fwd(op, l_taken);
      mov_a_imm(mark_fall);
      send_acc();
      branch_fwd(OP_SJMP, l_join);
      land_branch(l_taken);
      mov_a_imm(mark_taken);
      send_acc();
      land_branch(l_join);
      exp_bytes.push_back(taken ? mark_taken : mark_fall);
   endtask

   ////////////////////////////////////////
   // uart driver and test flow

   task automatic reset_dut();
      @(posedge i_clk);
      i_nrst    <= 1'b0;
      i_uart_rx <= 1'b1;
      repeat (10) @(posedge i_clk);
      wr_addr.delete();
      wr_data.delete();
      rx_bytes.delete();
      i_nrst <= 1'b1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge i_clk);
   endtask

   task automatic send_frame(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};  // stop, data, start
      for (int i = 0; i < 10; i++) begin
         @(posedge i_clk);
         i_uart_rx <= frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge i_clk);
      end
   endtask

   // whole image is random padding until a program is assembled over it
   task automatic fill_image();
      for (int a = 0; a < CODE_DEPTH; a++) image[a] = rand_byte();
      wp = 0;
      exp_bytes.delete();
   endtask

   task automatic load_image(input string name);
      int t;
      for (int a = 0; a < CODE_DEPTH; a++) send_frame(image[a]);
      t = 0;
      while (wr_addr.size() < CODE_DEPTH && t < 4 * CLKS_PER_BIT) begin
         @(posedge i_clk);
         t++;
      end
      if (wr_addr.size() != CODE_DEPTH) begin
         other_errs++;
         $display("ERROR %s: code load stopped after %0d of %0d bytes",
                  name, wr_addr.size(), CODE_DEPTH);
      end
   endtask

   task automatic check_frames(input string name);
      int t;
      int limit;
      limit = (exp_bytes.size() + 2) * 12 * CLKS_PER_BIT;
      t     = 0;
      while (rx_bytes.size() < exp_bytes.size() && t < limit) begin
         @(posedge i_clk);
         t++;
      end
      if (rx_bytes.size() < exp_bytes.size()) begin
         other_errs++;
         $display("ERROR %s: timeout, %0d of %0d uart bytes arrived",
                  name, rx_bytes.size(), exp_bytes.size());
      end else begin
         idle_cycles(30 * CLKS_PER_BIT);  // room for a stray frame
         if (rx_bytes.size() != exp_bytes.size()) begin
            other_errs++;
            $display("ERROR %s: %0d uart bytes arrived, %0d expected",
                     name, rx_bytes.size(), exp_bytes.size());
         end
         for (int i = 0; i < exp_bytes.size(); i++) check_byte(name, exp_bytes[i], rx_bytes[i]);
      end
   endtask

   ////////////////////////////////////////
   // directed tests

   task automatic load_check();
      reset_dut();
      fill_image();
      load_image("load");
      for (int i = 0; i < wr_addr.size(); i++) begin
         check_addr("load", code_addr_t'(i), wr_addr[i]);
         check_byte("load", image[i], wr_data[i]);
      end
      send_frame(rand_byte());  // loader is full, nothing may be written
      idle_cycles(2 * CLKS_PER_BIT);
      if (wr_addr.size() != CODE_DEPTH) begin
         other_errs++;
         $display("ERROR load: %0d code writes seen, %0d expected", wr_addr.size(), CODE_DEPTH);
      end
   endtask

   task automatic transmit_once();
      reset_dut();
      fill_image();
      mov_a_imm(8'h41);
      mov_dptr_imm(TX_ADDR);
      emit_byte(OP_MOVX_DPTR_A);
      branch_back(OP_SJMP, wp);
      exp_bytes.push_back(8'h41);
      load_image("transmit");
      check_frames("transmit");
   endtask

   task automatic reg_arith();
      byte_t v1;
      byte_t v2;
      byte_t acc;
      reset_dut();
      fill_image();
      v1 = rand_byte();
      v2 = rand_byte();
      emit_byte(rn_op(OP_MOV_RN_IMM, 0));
      emit_byte(v1);
      emit_byte(rn_op(OP_MOV_RN_IMM, 1));
      emit_byte(v2);
      emit_byte(rn_op(OP_INC_RN, 0));
      emit_byte(rn_op(OP_MOV_A_RN, 0));
      acc = v1 + 8'd1;
      send_acc_expect(acc);
      emit_byte(rn_op(OP_ADD_A_RN, 1));
      acc = acc + v2;
      send_acc_expect(acc);
      emit_byte(OP_DEC_A);
      acc = acc - 8'd1;
      send_acc_expect(acc);
      v1 = rand_byte();
      emit_byte(OP_XRL_A_IMM);
      emit_byte(v1);
      acc = acc ^ v1;
      send_acc_expect(acc);
      v2 = rand_byte();
      emit_byte(OP_ADD_A_IMM);
      emit_byte(v2);
      acc = acc + v2;
      send_acc_expect(acc);
      emit_byte(rn_op(OP_MOV_RN_A, 2));  // round trip through r2
      emit_byte(rn_op(OP_INC_RN, 2));
      emit_byte(rn_op(OP_MOV_A_RN, 2));
      acc = acc + 8'd1;
      send_acc_expect(acc);
      emit_byte(OP_CLR_A);
      send_acc_expect(8'h00);
      branch_back(OP_SJMP, wp);
      load_image("reg_arith");
      check_frames("reg_arith");
   endtask

   task automatic subb_case(input byte_t a, input byte_t imm);
      logic borrow;
      borrow = (imm > a);
      emit_byte(OP_CLR_C);
      mov_a_imm(a);
      emit_byte(OP_SUBB_A_IMM);
      emit_byte(imm);
      send_acc_expect(a - imm);
      branch_pair(OP_JC, borrow, 8'h43, 8'h4E);
      branch_pair(OP_JNC, !borrow, 8'h30, 8'h31);
   endtask

   task automatic subb_carry();
      byte_t a;
      byte_t imm;
      reset_dut();
      fill_image();
      a   = rand_byte();
      imm = rand_byte();
      subb_case(a, imm);
      subb_case(imm, a);  // swapped, so the other path unless equal
      mov_a_imm(8'h00);
      emit_byte(OP_SUBB_A_IMM);
      emit_byte(8'h01);   // sets carry before clr c
      emit_byte(OP_CLR_C);
      branch_pair(OP_JNC, 1'b1, 8'h5A, 8'hEE);
      branch_back(OP_SJMP, wp);
      load_image("subb_carry");
      check_frames("subb_carry");
   endtask

   task automatic branch_poll();
      int l;
      reset_dut();
      fill_image();
      emit_byte(OP_CLR_A);
      branch_fwd(OP_JZ, l);
      mov_a_imm(8'hEE);
      send_acc();
      land_branch(l);
      mov_a_imm(8'h07);
      branch_fwd(OP_JNZ, l);
      mov_a_imm(8'hEE);
      send_acc();
      land_branch(l);
      branch_fwd(OP_JZ, l);  // acc is 7, falls through
      emit_byte(OP_LJMP);
      emit_byte(8'hF1);      // upper address bits ignored, lands at 0x180
      emit_byte(8'h80);
      land_branch(l);
      mov_a_imm(8'hEE);
      send_acc();
      branch_back(OP_SJMP, wp);
      // three sends back to back, each polls busy first
      wp = 'h140;
      for (int i = 0; i < 3; i++) begin
         mov_a_imm(rand_byte());
         send_acc_expect(image[wp - 1]);
      end
      branch_back(OP_SJMP, wp);
      wp = 'h180;
      branch_back(OP_SJMP, 'h140);
      load_image("branch_poll");
      check_frames("branch_poll");
   endtask

   initial begin
      lfsr_state = 32'h7b9e;
      load_check();
      transmit_once();
      reg_arith();
      subb_carry();
      branch_poll();
      $display("checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src/ice51.sv
`timescale 1ns/1ps
`default_nettype none

module ice51
   import ice51_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   output logic       o_uart_tx,
   output logic       o_code_wr,
   output code_addr_t o_code_addr,
   output byte_t      o_code_data,
   input  byte_t      i_code_data
);

   logic       run;
   code_addr_t pc;
   logic       tx_start;
   byte_t      tx_byte;
   logic       tx_busy;

   insn_if insn ();

   // loads code memory, then hands the address over to the pc
   uart_rx_loader u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .i_pc        (pc),
      .o_run       (run),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data)
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_byte  (tx_byte),
      .o_busy  (tx_busy),
      .o_tx    (o_uart_tx)
   );

   cpu_sequencer u_seq (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_run       (run),
      .i_code_data (i_code_data),
      .o_pc        (pc),
      .insn        (insn.seq)
   );

   cpu_datapath u_dp (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .insn       (insn.dp),
      .i_tx_busy  (tx_busy),
      .o_tx_start (tx_start),
      .o_tx_byte  (tx_byte)
   );

endmodule

`default_nettype wire

//--- src/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath
   import ice51_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_nrst,
   insn_if.dp    insn,
   input  logic  i_tx_busy,
   output logic  o_tx_start,
   output byte_t o_tx_byte
);

   opcode_e    op_base;
   byte_t      acc;
   byte_t      acc_nxt;
   byte_t      regs [NUM_REGS];
   logic [2:0] rn_sel;
   byte_t      rn;
   byte_t      rn_nxt;
   logic       rn_wr;
   logic       carry;
   logic       carry_nxt;
   dptr_t      dptr;
   dptr_t      dptr_nxt;
   logic [8:0] sub_res;      // bit 8 is the borrow
   byte_t      movx_rd;

   assign op_base = op_class(insn.op);
   assign rn_sel  = insn.op[2:0];
   assign rn      = regs[rn_sel];

   assign sub_res = {1'b0, acc} - {1'b0, insn.operand1} - {8'd0, carry};
   assign movx_rd = (dptr == STATUS_ADDR) ? {7'd0, i_tx_busy} : 8'd0;

   ////////////////////////////////////////
   // execute

   always_comb begin
      acc_nxt   = acc;
      carry_nxt = carry;
      dptr_nxt  = dptr;
      rn_nxt    = rn;
      rn_wr     = 1'b0;
      if (insn.exec) begin
         case (op_base)
            OP_MOV_A_IMM:   acc_nxt = insn.operand1;
            OP_MOV_A_RN:    acc_nxt = rn;
            OP_ADD_A_IMM:   acc_nxt = acc + insn.operand1;  // carry untouched
            OP_ADD_A_RN:    acc_nxt = acc + rn;
            OP_DEC_A:       acc_nxt = acc - 8'd1;
            OP_CLR_A:       acc_nxt = 8'd0;
            OP_XRL_A_IMM:   acc_nxt = acc ^ insn.operand1;
            OP_MOVX_A_DPTR: acc_nxt = movx_rd;
            OP_SUBB_A_IMM: begin
               acc_nxt   = sub_res[7:0];
               carry_nxt = sub_res[8];
            end
            OP_CLR_C:       carry_nxt = 1'b0;
            OP_MOV_DPTR:    dptr_nxt = {insn.operand1, insn.operand2};
            OP_MOV_RN_IMM: begin
               rn_nxt = insn.operand1;
               rn_wr  = 1'b1;
            end
            OP_MOV_RN_A: begin
               rn_nxt = acc;
               rn_wr  = 1'b1;
            end
            OP_INC_RN: begin
               rn_nxt = rn + 8'd1;
               rn_wr  = 1'b1;
            end
            default: ;  // branches and no-ops
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else begin
         acc   <= acc_nxt;
         carry <= carry_nxt;
         dptr  <= dptr_nxt;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
      end else if (rn_wr) begin
         regs[rn_sel] <= rn_nxt;
      end
   end

   ////////////////////////////////////////
   // flags and uart

   assign insn.acc_zero = (acc == 8'd0);
   assign insn.carry    = carry;

   // software polls busy first, a start during a frame is dropped by the tx
   assign o_tx_start = insn.exec && (op_base == OP_MOVX_DPTR_A) && (dptr == TX_ADDR);
   assign o_tx_byte  = acc;

endmodule

`default_nettype wire

//--- src/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer
   import ice51_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_run,
   input  byte_t      i_code_data,
   output code_addr_t o_pc,
   insn_if.seq        insn
);

   seq_state_e state;
   seq_state_e state_nxt;
   code_addr_t pc;
   code_addr_t pc_nxt;
   opcode_e    op_q;
   byte_t      opnd1_q;
   byte_t      opnd2_q;
   logic [1:0] fetched_len;  // operand bytes of the opcode on the bus
   logic [1:0] latched_len;  // same, for the latched opcode
   logic       take_branch;
   code_addr_t rel_target;
   code_addr_t abs_target;

   // bytes following the opcode, unknown opcodes are single byte
   function automatic logic [1:0] operand_count(opcode_e op);
      case (op_class(op))
         OP_MOV_A_IMM, OP_MOV_RN_IMM, OP_ADD_A_IMM, OP_SUBB_A_IMM, OP_XRL_A_IMM,
         OP_SJMP, OP_JC, OP_JNC, OP_JZ, OP_JNZ: return 2'd1;
         OP_MOV_DPTR, OP_LJMP:                  return 2'd2;
         default:                               return 2'd0;
      endcase
   endfunction

   assign fetched_len = operand_count(opcode_e'(i_code_data));
   assign latched_len = operand_count(op_q);

   ////////////////////////////////////////
   // state machine

   always_comb begin
      state_nxt = state;
      case (state)
         FETCH:    if (i_run) state_nxt = OPCODE;
         OPCODE:   state_nxt = (fetched_len != 2'd0) ? OPERAND1 : EXECUTE;
         OPERAND1: state_nxt = (latched_len == 2'd2) ? OPERAND2 : EXECUTE;
         OPERAND2: state_nxt = EXECUTE;
         EXECUTE:  state_nxt = FETCH;
         default:  state_nxt = FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= FETCH;
      else         state <= state_nxt;
   end

   // memory data lags the address by a cycle, so each byte lands one state later
   always_ff @(posedge i_clk) begin
      case (state)
         OPCODE:   op_q    <= opcode_e'(i_code_data);
         OPERAND1: opnd1_q <= i_code_data;
         OPERAND2: opnd2_q <= i_code_data;
         default: ;
      endcase
   end

   ////////////////////////////////////////
   // program counter

   always_comb begin
      case (op_class(op_q))
         OP_SJMP: take_branch = 1'b1;
         OP_JC:   take_branch = insn.carry;
         OP_JNC:  take_branch = !insn.carry;
         OP_JZ:   take_branch = insn.acc_zero;
         OP_JNZ:  take_branch = !insn.acc_zero;
         default: take_branch = 1'b0;
      endcase
   end

   // pc already points past the instruction in EXECUTE
   assign rel_target = pc + code_addr_t'($signed(opnd1_q));
   assign abs_target = code_addr_t'({opnd1_q, opnd2_q});  // low bits of addr16

   always_comb begin
      pc_nxt = pc;
      case (state)
         FETCH:    if (i_run) pc_nxt = pc + 1'b1;
         OPCODE:   if (fetched_len != 2'd0) pc_nxt = pc + 1'b1;
         OPERAND1: if (latched_len == 2'd2) pc_nxt = pc + 1'b1;
         EXECUTE: begin
            if (op_class(op_q) == OP_LJMP) pc_nxt = abs_target;
            else if (take_branch)          pc_nxt = rel_target;
         end
         default: ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pc <= '0;
      else         pc <= pc_nxt;  // wraps at code depth
   end

   assign o_pc          = pc;
   assign insn.op       = op_q;
   assign insn.operand1 = opnd1_q;
   assign insn.operand2 = opnd2_q;
   assign insn.exec     = (state == EXECUTE);

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import ice51_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_start,
   input  byte_t i_byte,
   output logic  o_busy,
   output logic  o_tx
);

   tx_state_e  state;
   baud_cnt_t  clk_cnt;
   logic [2:0] bit_cnt;
   byte_t      shift;
   logic       bit_end;

   assign bit_end = (clk_cnt == BIT_END);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         clk_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         if (state == TX_IDLE) clk_cnt <= '0;
         else                  clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
         case (state)
            TX_IDLE:  if (i_start) state <= TX_START;  // start while busy is lost
            TX_START: begin
               if (bit_end) begin
                  bit_cnt <= '0;
                  state   <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) state <= TX_STOP;
               end
            end
            TX_STOP:  if (bit_end) state <= TX_IDLE;
            default:  state <= TX_IDLE;
         endcase
      end
   end

   // lsb first, matches the loader
   always_ff @(posedge i_clk) begin
      if ((state == TX_IDLE) && i_start)     shift <= i_byte;
      else if ((state == TX_DATA) && bit_end) shift <= {1'b1, shift[7:1]};
   end

   assign o_busy = (state != TX_IDLE);

   always_comb begin
      case (state)
         TX_START: o_tx = 1'b0;
         TX_DATA:  o_tx = shift[0];
         default:  o_tx = 1'b1;  // idle and stop
      endcase
   end

endmodule

`default_nettype wire

//--- src/uart_rx_loader.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_loader
   import ice51_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   input  code_addr_t i_pc,
   output logic       o_run,
   output logic       o_code_wr,
   output code_addr_t o_code_addr,
   output byte_t      o_code_data
);

   rx_state_e  state;
   logic       rx_q;        // resynced line
   baud_cnt_t  clk_cnt;
   logic [2:0] bit_cnt;
   byte_t      shift;
   code_addr_t byte_cnt;    // next code address during load
   logic       bit_end;
   logic       frame_done;

   ////////////////////////////////////////
   // receiver

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_q <= 1'b1;  // line idles high
      else         rx_q <= i_uart_rx;
   end

   assign bit_end    = (clk_cnt == BIT_END);
   assign frame_done = (state == RX_STOP) && bit_end;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         clk_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!rx_q) state <= RX_START;  // falling edge
            end
            RX_START: begin
               if (clk_cnt == HALF_BIT) begin
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= rx_q ? RX_IDLE : RX_DATA;  // drop a glitch
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) state <= RX_STOP;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  state   <= RX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first, shifts down from the top
   always_ff @(posedge i_clk) begin
      if ((state == RX_DATA) && bit_end) shift <= {rx_q, shift[7:1]};
   end

   ////////////////////////////////////////
   // code memory load

   assign o_code_wr = frame_done && !o_run;  // frames after load are dropped

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt <= '0;
         o_run    <= 1'b0;
      end else if (o_code_wr) begin
         byte_cnt <= byte_cnt + 1'b1;
         if (byte_cnt == code_addr_t'(CODE_DEPTH - 1)) o_run <= 1'b1;  // last byte
      end
   end

   assign o_code_addr = o_run ? i_pc : byte_cnt;
   assign o_code_data = shift;

endmodule

`default_nettype wire

//--- src/insn_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction out of the sequencer, flags back from the datapath
interface insn_if
   import ice51_pkg::*;
();

   opcode_e op;        // raw opcode byte, rn still in bits 2:0
   byte_t   operand1;  // imm, offset or high address byte
   byte_t   operand2;  // low address byte of 3-byte forms
   logic    exec;      // one cycle in EXECUTE

   logic    acc_zero;
   logic    carry;

   modport seq (
      output op, operand1, operand2, exec,
      input  acc_zero, carry
   );

   modport dp (
      input  op, operand1, operand2, exec,
      output acc_zero, carry
   );

endinterface

`default_nettype wire

//--- src/ice51_pkg.sv
`default_nettype none

package ice51_pkg;

   ////////////////////////////////////////
   // sizes and addresses

   localparam int CLKS_PER_BIT = 104;  // clocks per uart bit
   localparam int CODE_DEPTH   = 512;  // program bytes loaded
   localparam int NUM_REGS     = 8;    // r0..r7

   typedef logic [7:0]                      byte_t;
   typedef logic [$clog2(CODE_DEPTH)-1:0]   code_addr_t;
   typedef logic [15:0]                     dptr_t;
   typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

   localparam dptr_t TX_ADDR     = 16'h0201;  // movx write sends acc
   localparam dptr_t STATUS_ADDR = 16'h0200;  // movx read returns tx busy

   // bit timing, counted from zero
   localparam baud_cnt_t BIT_END  = baud_cnt_t'(CLKS_PER_BIT - 1);
   localparam baud_cnt_t HALF_BIT = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

   ////////////////////////////////////////
   // opcodes

   // register forms carry rn in the low three bits
   typedef enum logic [7:0] {
      OP_LJMP        = 8'h02,
      OP_INC_RN      = 8'h08,
      OP_DEC_A       = 8'h14,
      OP_ADD_A_IMM   = 8'h24,
      OP_ADD_A_RN    = 8'h28,
      OP_JC          = 8'h40,
      OP_JNC         = 8'h50,
      OP_JZ          = 8'h60,
      OP_XRL_A_IMM   = 8'h64,
      OP_JNZ         = 8'h70,
      OP_MOV_A_IMM   = 8'h74,
      OP_MOV_RN_IMM  = 8'h78,
      OP_SJMP        = 8'h80,
      OP_MOV_DPTR    = 8'h90,
      OP_SUBB_A_IMM  = 8'h94,
      OP_CLR_C       = 8'hC3,
      OP_MOVX_A_DPTR = 8'hE0,
      OP_CLR_A       = 8'hE4,
      OP_MOV_A_RN    = 8'hE8,
      OP_MOVX_DPTR_A = 8'hF0,
      OP_MOV_RN_A    = 8'hF8
   } opcode_e;

   typedef enum logic [2:0] {FETCH, OPCODE, OPERAND1, OPERAND2, EXECUTE} seq_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

   // folds r0..r7 variants onto their base opcode, leaves the rest alone
   function automatic opcode_e op_class(opcode_e op);
      opcode_e base;
      base = opcode_e'({op[7:3], 3'b000});
      case (base)
         OP_INC_RN, OP_ADD_A_RN, OP_MOV_RN_IMM, OP_MOV_A_RN, OP_MOV_RN_A: return base;
         default: return op;
      endcase
   endfunction

endpackage

`default_nettype wire
